//--- Makefile
TOP = csr_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f all.f --top-module $(TOP)

# pass or fail is taken from the log, not from the exit code of the run
sim:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- all.f
+incdir+tests
verilog/csr_pkg.sv
verilog/csr_access_decode.sv
verilog/machine_trap_regs.sv
verilog/perf_event_map.sv
verilog/perf_counter.sv
verilog/csr_read_mux.sv
verilog/csr_regfile_top.sv
tests/csr_tb.sv

//--- tests/csr_tb_tasks.svh
// csr access and wait helpers, value checks and the directed test tasks
`ifndef CSR_TB_TASKS_SVH
`define CSR_TB_TASKS_SVH

//////////////////////////////////////////////////////////////////////////////
// checks
//////////////////////////////////////////////////////////////////////////////

task automatic compare_word(input string name, input xlen_t got, input xlen_t exp);
  checks++;
  assert (got === exp) else begin
    $display("MISMATCH t=%0t %s got=%h exp=%h", $time, name, got, exp);
    errors++;
  end
endtask

task automatic compare_below(input string name, input xlen_t got, input xlen_t limit);
  checks++;
  assert (got < limit) else begin
    $display("MISMATCH t=%0t %s got=%h exp=below %h", $time, name, got, limit);
    errors++;
  end
endtask

task automatic report_test(input string name, input int errs_before);
  tests++;
  $display("%-22s %s, %0d errors", name, (errors == errs_before) ? "ok" : "FAIL",
           errors - errs_before);
endtask

//////////////////////////////////////////////////////////////////////////////
// bus and wait helpers
//////////////////////////////////////////////////////////////////////////////

// one access cycle, then one idle cycle; rdata sampled mid-cycle
task automatic access_csr(input csr_op_e op, input csr_addr_t addr, input xlen_t wdata,
                          output xlen_t rdata);
  csr_req_t req;
  req        = '0;
  req.access = 1'b1;
  req.addr   = addr;
  req.wdata  = wdata;
  req.op     = op;
  @(posedge clk);
  csr_req <= req;
  @(negedge clk);
  rdata = csr_rdata;
  @(posedge clk);
  csr_req <= '0;
endtask

task automatic read_csr(input csr_addr_t addr, output xlen_t data);
  access_csr(CSR_OP_NONE, addr, '0, data);
endtask

task automatic write_csr(input csr_op_e op, input csr_addr_t addr, input xlen_t data);
  xlen_t discard;
  access_csr(op, addr, data, discard);
endtask

// trap control held for exactly one cycle
task automatic pulse_trap(input trap_ctrl_t ctrl);
  @(posedge clk);
  trap_ctrl <= ctrl;
  @(posedge clk);
  trap_ctrl <= '0;
endtask

task automatic wait_irq_level(input logic level);
  int n;
  n = 0;
  do begin
    @(negedge clk);
    n++;
  end while (m_irq_enable !== level && n < WAIT_LIMIT);
  checks++;
  assert (m_irq_enable === level) else begin
    $display("timeout at t=%0t: m_irq_enable_o did not go to %0b within %0d cycles",
             $time, level, WAIT_LIMIT);
    errors++;
  end
endtask

// random decoded instructions and stores, then a quiet gap of three cycles
task automatic drive_events(input int cycles, output int n_instr, output int n_store);
  perf_events_t ev;
  xlen_t        r;
  n_instr = 0;
  n_store = 0;
  for (int i = 0; i < cycles; i++) begin
    r              = $urandom;
    ev             = '0;
    ev.id_valid    = r[0];
    ev.is_decoding = r[1];
    ev.mem_store   = r[2];
    // loads and branches ride along, their counters stay off
    ev.mem_load    = r[3];
    ev.branch      = r[4];
    if (ev.id_valid && ev.is_decoding) begin
      n_instr++;
    end
    if (ev.mem_store) begin
      n_store++;
    end
    @(posedge clk);
    perf_events <= ev;
  end
  @(posedge clk);
  perf_events <= '0;
  repeat (3) @(posedge clk);
endtask

//////////////////////////////////////////////////////////////////////////////
// directed tests
//////////////////////////////////////////////////////////////////////////////

task automatic verify_reset_identity();
  int    errs_before;
  xlen_t d;
  errs_before = errors;
  // only mpp = M after reset
  read_csr(CSR_MSTATUS, d);
  compare_word("mstatus", d, 32'h0000_1800);
  // cluster id from bit 5 up, core id in the low nibble
  read_csr(CSR_MHARTID, d);
  compare_word("mhartid", d, (xlen_t'(CLUSTER_ID) << 5) | xlen_t'(CORE_ID));
  read_csr(CSR_MTVEC, d);
  compare_word("mtvec", d, xlen_t'(BOOT_ADDR) << 8);
  compare_word("mtvec_o", xlen_t'(mtvec), xlen_t'(BOOT_ADDR));
  read_csr(CSR_PCMR, d);
  compare_word("pcmr", d, 32'd3);
  read_csr(CSR_PCER, d);
  compare_word("pcer", d, 32'd0);
  read_csr(CSR_MEPC, d);
  compare_word("mepc", d, 32'd0);
  report_test("reset and identity", errs_before);
endtask

task automatic exercise_rmw();
  int    errs_before;
  xlen_t exp;
  xlen_t mask;
  xlen_t d;
  errs_before = errors;
  exp = $urandom;
  write_csr(CSR_OP_WRITE, CSR_MEPC, exp);
  read_csr(CSR_MEPC, d);
  compare_word("mepc after write", d, exp);
  for (int i = 0; i < 4; i++) begin
    mask = $urandom;
    write_csr(CSR_OP_SET, CSR_MEPC, mask);
    exp = exp | mask;
    read_csr(CSR_MEPC, d);
    compare_word("mepc after set", d, exp);
    mask = $urandom;
    write_csr(CSR_OP_CLEAR, CSR_MEPC, mask);
    exp = exp & ~mask;
    read_csr(CSR_MEPC, d);
    compare_word("mepc after clear", d, exp);
  end
  // access without an op is a plain read
  write_csr(CSR_OP_NONE, CSR_MEPC, $urandom);
  read_csr(CSR_MEPC, d);
  compare_word("mepc after none", d, exp);
  report_test("read-modify-write", errs_before);
endtask

task automatic enter_trap_cases();
  int         errs_before;
  xlen_t      d;
  xlen_t      pc_a;
  xlen_t      pc_b;
  trap_ctrl_t ctrl;
  errs_before = errors;
  pc_a = $urandom;
  pc_b = $urandom;
  @(posedge clk);
  pc_if <= pc_a;
  pc_id <= pc_b;

  // fetch pc, interrupt cause 0x0b
  write_csr(CSR_OP_SET, CSR_MSTATUS, 32'h8);
  wait_irq_level(1'b1);
  ctrl            = '0;
  ctrl.save_cause = 1'b1;
  ctrl.save_if    = 1'b1;
  ctrl.cause      = 6'h2B;
  pulse_trap(ctrl);
  wait_irq_level(1'b0);
  read_csr(CSR_MEPC, d);
  compare_word("mepc from pc_if", d, pc_a);
  read_csr(CSR_MCAUSE, d);
  compare_word("mcause irq", d, 32'h8000_000B);
  // mpie set, mie clear, mpp M
  read_csr(CSR_MSTATUS, d);
  compare_word("mstatus after trap", d, 32'h0000_1880);

  // decode pc, exception cause 2
  write_csr(CSR_OP_SET, CSR_MSTATUS, 32'h8);
  wait_irq_level(1'b1);
  ctrl            = '0;
  ctrl.save_cause = 1'b1;
  ctrl.save_id    = 1'b1;
  ctrl.cause      = 6'h02;
  pulse_trap(ctrl);
  wait_irq_level(1'b0);
  read_csr(CSR_MEPC, d);
  compare_word("mepc from pc_id", d, pc_b);
  read_csr(CSR_MCAUSE, d);
  compare_word("mcause exception", d, 32'h0000_0002);
  read_csr(CSR_MSTATUS, d);
  compare_word("mstatus after trap", d, 32'h0000_1880);
  report_test("trap entry", errs_before);
endtask

task automatic return_from_trap();
  int         errs_before;
  xlen_t      d;
  xlen_t      ret_pc;
  trap_ctrl_t ctrl;
  errs_before = errors;
  ret_pc = $urandom;
  // mpie set, mie clear
  write_csr(CSR_OP_WRITE, CSR_MSTATUS, 32'h80);
  write_csr(CSR_OP_WRITE, CSR_MEPC, ret_pc);
  ctrl      = '0;
  ctrl.mret = 1'b1;
  pulse_trap(ctrl);
  wait_irq_level(1'b1);
  compare_word("epc_o", epc, ret_pc);
  read_csr(CSR_MSTATUS, d);
  compare_word("mstatus after mret", d, 32'h0000_1888);
  report_test("mret", errs_before);
endtask

task automatic count_events();
  int    errs_before;
  int    n_instr;
  int    n_store;
  int    extra_i;
  int    extra_s;
  xlen_t d;
  errs_before = errors;
  // retired and store counters on, bank cleared
  write_csr(CSR_OP_WRITE, CSR_PCMR, 32'h1);
  write_csr(CSR_OP_WRITE, CSR_PCER, 32'h42);
  write_csr(CSR_OP_WRITE, CSR_PCCR_ALL, 32'h0);
  drive_events(40, n_instr, n_store);
  read_csr(CSR_PCCR_BASE + 12'd1, d);
  compare_word("pccr1 retired", d, xlen_t'(n_instr));
  read_csr(CSR_PCCR_BASE + 12'd6, d);
  compare_word("pccr6 stores", d, xlen_t'(n_store));

  // store counter masked in pcer
  write_csr(CSR_OP_WRITE, CSR_PCER, 32'h2);
  drive_events(20, extra_i, extra_s);
  n_instr += extra_i;
  read_csr(CSR_PCCR_BASE + 12'd1, d);
  compare_word("pccr1 retired", d, xlen_t'(n_instr));
  read_csr(CSR_PCCR_BASE + 12'd6, d);
  compare_word("pccr6 masked", d, xlen_t'(n_store));

  // global enable off, both frozen
  write_csr(CSR_OP_WRITE, CSR_PCER, 32'h42);
  write_csr(CSR_OP_WRITE, CSR_PCMR, 32'h2);
  drive_events(20, extra_i, extra_s);
  read_csr(CSR_PCCR_BASE + 12'd1, d);
  compare_word("pccr1 disabled", d, xlen_t'(n_instr));
  read_csr(CSR_PCCR_BASE + 12'd6, d);
  compare_word("pccr6 disabled", d, xlen_t'(n_store));
  report_test("event counting", errs_before);
endtask

task automatic write_all_saturate();
  int    errs_before;
  xlen_t d;
  errs_before = errors;
  // cycle counter only, saturating
  write_csr(CSR_OP_WRITE, CSR_PCMR, 32'h3);
  write_csr(CSR_OP_WRITE, CSR_PCER, 32'h1);
  write_csr(CSR_OP_WRITE, CSR_PCCR_ALL, 32'hFFFF_FFFF);
  for (int i = 0; i < N_PERF_CNT; i++) begin
    read_csr(CSR_PCCR_BASE + csr_addr_t'(i), d);
    compare_word($sformatf("pccr%0d all ones", i), d, 32'hFFFF_FFFF);
  end
  repeat (4) @(posedge clk);
  read_csr(CSR_PCCR_BASE, d);
  compare_word("pccr0 saturated", d, 32'hFFFF_FFFF);
  // saturation off, next increment wraps
  write_csr(CSR_OP_WRITE, CSR_PCMR, 32'h1);
  read_csr(CSR_PCCR_BASE, d);
  compare_below("pccr0 wrapped", d, 32'd4);
  report_test("write-all and saturate", errs_before);
endtask

`endif

//--- tests/csr_tb.sv
// testbench top for the csr block: clock, reset, dut instance, test sequence and summary
`timescale 1ns/100ps
`default_nettype none

module csr_tb
  import csr_pkg::*;
();

  // cycles before a wait gives up
  localparam int          WAIT_LIMIT = 20;
  // fixed identity straps
  localparam boot_addr_t  BOOT_ADDR  = 24'h1C0080;
  localparam core_id_t    CORE_ID    = 4'h5;
  localparam cluster_id_t CLUSTER_ID = 6'h2A;

  logic         clk;
  logic         rst_n;
  csr_req_t     csr_req;
  trap_ctrl_t   trap_ctrl;
  xlen_t        pc_if;
  xlen_t        pc_id;
  perf_events_t perf_events;
  boot_addr_t   boot_addr;
  core_id_t     core_id;
  cluster_id_t  cluster_id;
  xlen_t        csr_rdata;
  xlen_t        epc;
  boot_addr_t   mtvec;
  logic         m_irq_enable;

  // run bookkeeping
  int errors;
  int checks;
  int tests;

  csr_regfile_top u_csr_regfile_top (
    .clk            (clk),
    .rst_n          (rst_n),
    .csr_req_i      (csr_req),
    .trap_ctrl_i    (trap_ctrl),
    .pc_if_i        (pc_if),
    .pc_id_i        (pc_id),
    .perf_events_i  (perf_events),
    .boot_addr_i    (boot_addr),
    .core_id_i      (core_id),
    .cluster_id_i   (cluster_id),
    .csr_rdata_o    (csr_rdata),
    .epc_o          (epc),
    .mtvec_o        (mtvec),
    .m_irq_enable_o (m_irq_enable)
  );

  // 100 ns period
  always #50 clk = ~clk;

  `include "csr_tb_tasks.svh"

  ////////////////////////////////////////////////////////////////////////////
  // sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    clk    = 1'b0;
    errors = 0;
    checks = 0;
    tests  = 0;
    void'($urandom(32'h415a));

    // all inputs quiet, reset held
    rst_n       <= 1'b0;
    csr_req     <= '0;
    trap_ctrl   <= '0;
    pc_if       <= '0;
    pc_id       <= '0;
    perf_events <= '0;
    boot_addr   <= BOOT_ADDR;
    core_id     <= CORE_ID;
    cluster_id  <= CLUSTER_ID;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    verify_reset_identity();
    exercise_rmw();
    enter_trap_cases();
    return_from_trap();
    count_events();
    write_all_saturate();

    $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/csr_access_decode.sv
// csr address decoder, read-modify-write data and per-register write strobes
`timescale 1ns/100ps
`default_nettype none

module csr_access_decode
  import csr_pkg::*;
(
  input  wire          clk,
  input  wire          rst_n,
  input  wire csr_req_t csr_req_i,
  // current value of the addressed csr
  input  wire xlen_t   rdata_i,
  output xlen_t        wdata_o,
  output csr_wstrobe_t wstrobe_o
);

  logic      wr_en;
  csr_addr_t pccr_off;
  logic      pccr_range;
  perf_idx_t pccr_idx;

  // any op but none writes
  assign wr_en = csr_req_i.access && (csr_req_i.op != CSR_OP_NONE);

  ////////////////////////////////////////////////////////////////////////////
  // read-modify-write
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (csr_req_i.op)
      CSR_OP_SET:   wdata_o = rdata_i | csr_req_i.wdata;
      CSR_OP_CLEAR: wdata_o = rdata_i & ~csr_req_i.wdata;
      // write, and none which has no strobe anyway
      default:      wdata_o = csr_req_i.wdata;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // address decode
  ////////////////////////////////////////////////////////////////////////////

  // offset into the counter window
  assign pccr_off   = csr_req_i.addr - CSR_PCCR_BASE;
  assign pccr_range = (csr_req_i.addr >= CSR_PCCR_BASE) &&
                      (pccr_off < csr_addr_t'(N_PERF_CNT));
  assign pccr_idx   = pccr_off[PERF_IDX_W-1:0];

  always_comb begin
    wstrobe_o         = '0;
    wstrobe_o.mstatus = wr_en && (csr_req_i.addr == CSR_MSTATUS);
    wstrobe_o.mepc    = wr_en && (csr_req_i.addr == CSR_MEPC);
    wstrobe_o.mcause  = wr_en && (csr_req_i.addr == CSR_MCAUSE);
    wstrobe_o.pcer    = wr_en && (csr_req_i.addr == CSR_PCER);
    wstrobe_o.pcmr    = wr_en && (csr_req_i.addr == CSR_PCMR);
    // broadcast write hits every counter
    if (wr_en && (csr_req_i.addr == CSR_PCCR_ALL)) begin
      wstrobe_o.pccr = '1;
    end else if (wr_en && pccr_range) begin
      wstrobe_o.pccr = perf_mask_t'(1) << pccr_idx;
    end
  end

  // no x on op during an access, else strobes and rmw data go undefined
  a_op_known: assert property (
    @(posedge clk) disable iff (!rst_n)
    csr_req_i.access |-> !$isunknown(csr_req_i.op)
  );

endmodule

`default_nettype wire

//--- verilog/csr_pkg.sv
// shared widths, csr addresses, op and privilege enums, request, trap and strobe structs
`default_nettype none

package csr_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [31:0] xlen_t;
  typedef logic [11:0] csr_addr_t;
  // bit 5 interrupt flag, bits 4:0 code
  typedef logic [5:0]  cause_t;
  // trap vector base, read back shifted by 8
  typedef logic [23:0] boot_addr_t;
  typedef logic [3:0]  core_id_t;
  typedef logic [5:0]  cluster_id_t;

  // performance counter bank
  localparam int N_PERF_CNT = 11;
  localparam int PERF_IDX_W = $clog2(N_PERF_CNT);
  typedef logic [N_PERF_CNT-1:0] perf_mask_t;
  typedef logic [PERF_IDX_W-1:0] perf_idx_t;
  // mode register, enable and saturation
  typedef logic [1:0]            pcmr_t;

  typedef enum logic [1:0] {
    CSR_OP_NONE  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  ////////////////////////////////////////////////////////////////////////////
  // csr map
  ////////////////////////////////////////////////////////////////////////////

  localparam csr_addr_t CSR_MSTATUS   = 12'h300;
  localparam csr_addr_t CSR_MTVEC     = 12'h305;
  localparam csr_addr_t CSR_MEPC      = 12'h341;
  localparam csr_addr_t CSR_MCAUSE    = 12'h342;
  localparam csr_addr_t CSR_MHARTID   = 12'hF14;
  // counters at 780..78a, 79f writes all of them
  localparam csr_addr_t CSR_PCCR_BASE = 12'h780;
  localparam csr_addr_t CSR_PCCR_ALL  = 12'h79F;
  localparam csr_addr_t CSR_PCER      = 12'h7A0;
  localparam csr_addr_t CSR_PCMR      = 12'h7A1;

  // field positions
  localparam int MSTATUS_MIE_BIT  = 3;
  localparam int MSTATUS_MPIE_BIT = 7;
  localparam int MSTATUS_MPP_LSB  = 11;
  localparam int PCMR_EN_BIT      = 0;
  localparam int PCMR_SAT_BIT     = 1;

  // counting enabled, saturating
  localparam pcmr_t PCMR_RESET = 2'b11;

  ////////////////////////////////////////////////////////////////////////////
  // bundles
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic      access;
    csr_addr_t addr;
    xlen_t     wdata;
    csr_op_e   op;
  } csr_req_t;

  typedef struct packed {
    logic   save_cause;
    logic   save_if;
    logic   save_id;
    logic   mret;
    cause_t cause;
  } trap_ctrl_t;

  typedef struct packed {
    logic id_valid;
    logic is_decoding;
    logic is_compressed;
    logic imiss;
    logic pc_set;
    logic jump;
    logic branch;
    logic branch_taken;
    logic ld_stall;
    logic jr_stall;
    logic mem_load;
    logic mem_store;
  } perf_events_t;

  typedef struct packed {
    logic       mstatus;
    logic       mepc;
    logic       mcause;
    logic       pcer;
    logic       pcmr;
    perf_mask_t pccr;
  } csr_wstrobe_t;

endpackage

`default_nettype wire

//--- verilog/csr_read_mux.sv
// csr read data select over machine registers, hart id, pcer, pcmr and counters
`timescale 1ns/100ps
`default_nettype none

module csr_read_mux
  import csr_pkg::*;
(
  input  wire csr_addr_t                    addr_i,
  input  wire xlen_t                        mstatus_i,
  input  wire xlen_t                        mepc_i,
  input  wire cause_t                       mcause_i,
  input  wire boot_addr_t                   boot_addr_i,
  input  wire core_id_t                     core_id_i,
  input  wire cluster_id_t                  cluster_id_i,
  input  wire perf_mask_t                   pcer_i,
  input  wire pcmr_t                        pcmr_i,
  input  wire xlen_t [N_PERF_CNT-1:0]       count_i,
  output xlen_t                             rdata_o
);

  csr_addr_t pccr_off;
  logic      pccr_range;
  perf_idx_t pccr_idx;

  // 780..78a only, the rest of the window reads 0
  assign pccr_off   = addr_i - CSR_PCCR_BASE;
  assign pccr_range = (addr_i >= CSR_PCCR_BASE) && (pccr_off < csr_addr_t'(N_PERF_CNT));
  assign pccr_idx   = pccr_off[PERF_IDX_W-1:0];

  always_comb begin
    rdata_o = '0;
    case (addr_i)
      CSR_MSTATUS: rdata_o = mstatus_i;
      // base comes from the boot address, 256 byte aligned
      CSR_MTVEC:   rdata_o = {boot_addr_i, 8'h00};
      CSR_MEPC:    rdata_o = mepc_i;
      // interrupt flag moves up to the msb
      CSR_MCAUSE:  rdata_o = {mcause_i[5], 26'b0, mcause_i[4:0]};
      CSR_MHARTID: rdata_o = {21'b0, cluster_id_i, 1'b0, core_id_i};
      CSR_PCER:    rdata_o = xlen_t'(pcer_i);
      CSR_PCMR:    rdata_o = xlen_t'(pcmr_i);
      default: begin
        if (pccr_range) begin
          rdata_o = count_i[pccr_idx];
        end
      end
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/csr_regfile_top.sv
// csr block top: decoder, trap registers, event map, counter bank and read mux
`timescale 1ns/100ps
`default_nettype none

module csr_regfile_top
  import csr_pkg::*;
(
  input  wire               clk,
  input  wire               rst_n,
  input  wire csr_req_t     csr_req_i,
  input  wire trap_ctrl_t   trap_ctrl_i,
  input  wire xlen_t        pc_if_i,
  input  wire xlen_t        pc_id_i,
  input  wire perf_events_t perf_events_i,
  input  wire boot_addr_t   boot_addr_i,
  input  wire core_id_t     core_id_i,
  input  wire cluster_id_t  cluster_id_i,
  output xlen_t             csr_rdata_o,
  output xlen_t             epc_o,
  output boot_addr_t        mtvec_o,
  output logic              m_irq_enable_o
);

  xlen_t                  rdata;
  xlen_t                  wdata;
  csr_wstrobe_t           wstrobe;
  xlen_t                  mstatus;
  xlen_t                  mepc;
  cause_t                 mcause;
  perf_mask_t             inc_req;
  perf_mask_t             pcer;
  pcmr_t                  pcmr;
  xlen_t [N_PERF_CNT-1:0] count;

  csr_access_decode u_csr_access_decode (
    .clk       (clk),
    .rst_n     (rst_n),
    .csr_req_i (csr_req_i),
    .rdata_i   (rdata),
    .wdata_o   (wdata),
    .wstrobe_o (wstrobe)
  );

  machine_trap_regs u_machine_trap_regs (
    .clk            (clk),
    .rst_n          (rst_n),
    .wstrobe_i      (wstrobe),
    .wdata_i        (wdata),
    .trap_ctrl_i    (trap_ctrl_i),
    .pc_if_i        (pc_if_i),
    .pc_id_i        (pc_id_i),
    .mstatus_o      (mstatus),
    .mepc_o         (mepc),
    .mcause_o       (mcause),
    .epc_o          (epc_o),
    .m_irq_enable_o (m_irq_enable_o)
  );

  perf_event_map u_perf_event_map (
    .clk           (clk),
    .rst_n         (rst_n),
    .perf_events_i (perf_events_i),
    .wstrobe_i     (wstrobe),
    .wdata_i       (wdata),
    .inc_req_o     (inc_req),
    .pcer_o        (pcer),
    .pcmr_o        (pcmr)
  );

  // counter bank, saturation shared from pcmr
  for (genvar i = 0; i < N_PERF_CNT; i++) begin : gen_cnt
    perf_counter u_perf_counter (
      .clk      (clk),
      .rst_n    (rst_n),
      .inc_i    (inc_req[i]),
      .sat_en_i (pcmr[PCMR_SAT_BIT]),
      .we_i     (wstrobe.pccr[i]),
      .wdata_i  (wdata),
      .count_o  (count[i])
    );
  end

  csr_read_mux u_csr_read_mux (
    .addr_i       (csr_req_i.addr),
    .mstatus_i    (mstatus),
    .mepc_i       (mepc),
    .mcause_i     (mcause),
    .boot_addr_i  (boot_addr_i),
    .core_id_i    (core_id_i),
    .cluster_id_i (cluster_id_i),
    .pcer_i       (pcer),
    .pcmr_i       (pcmr),
    .count_i      (count),
    .rdata_o      (rdata)
  );

  assign csr_rdata_o = rdata;
  // vector base is read-only, straight from the boot address
  assign mtvec_o     = boot_addr_i;

endmodule

`default_nettype wire

//--- verilog/machine_trap_regs.sv
// machine status, exception pc and cause registers with trap entry and mret
`timescale 1ns/100ps
`default_nettype none

module machine_trap_regs
  import csr_pkg::*;
(
  input  wire               clk,
  input  wire               rst_n,
  input  wire csr_wstrobe_t wstrobe_i,
  input  wire xlen_t        wdata_i,
  input  wire trap_ctrl_t   trap_ctrl_i,
  input  wire xlen_t        pc_if_i,
  input  wire xlen_t        pc_id_i,
  output xlen_t             mstatus_o,
  output xlen_t             mepc_o,
  output cause_t            mcause_o,
  output xlen_t             epc_o,
  output logic              m_irq_enable_o
);

  logic      mie_q;
  logic      mie_d;
  logic      mpie_q;
  logic      mpie_d;
  xlen_t     mepc_q;
  xlen_t     mepc_d;
  cause_t    mcause_q;
  cause_t    mcause_d;

  ////////////////////////////////////////////////////////////////////////////
  // next state
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    mie_d    = mie_q;
    mpie_d   = mpie_q;
    mepc_d   = mepc_q;
    mcause_d = mcause_q;

    // software writes first
    if (wstrobe_i.mstatus) begin
      mie_d  = wdata_i[MSTATUS_MIE_BIT];
      mpie_d = wdata_i[MSTATUS_MPIE_BIT];
    end
    if (wstrobe_i.mepc) begin
      mepc_d = wdata_i;
    end
    if (wstrobe_i.mcause) begin
      mcause_d = {wdata_i[31], wdata_i[4:0]};
    end

    // trap controller overrides the write
    if (trap_ctrl_i.save_cause) begin
      // id stage pc unless the fetch pc is asked for
      mepc_d   = trap_ctrl_i.save_if ? pc_if_i : pc_id_i;
      mpie_d   = mie_q;
      mie_d    = 1'b0;
      mcause_d = trap_ctrl_i.cause;
    end else if (trap_ctrl_i.mret) begin
      mie_d  = mpie_q;
      mpie_d = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mie_q    <= 1'b0;
      mpie_q   <= 1'b0;
      mepc_q   <= '0;
      mcause_q <= '0;
    end else begin
      mie_q    <= mie_d;
      mpie_q   <= mpie_d;
      mepc_q   <= mepc_d;
      mcause_q <= mcause_d;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // outputs
  ////////////////////////////////////////////////////////////////////////////

  // assembled view, unimplemented fields read 0
  always_comb begin
    mstatus_o                         = '0;
    mstatus_o[MSTATUS_MIE_BIT]        = mie_q;
    mstatus_o[MSTATUS_MPIE_BIT]       = mpie_q;
    // only M implemented, previous mode is always M
    mstatus_o[MSTATUS_MPP_LSB +: 2]   = PRIV_LVL_M;
  end

  assign mepc_o         = mepc_q;
  assign mcause_o       = mcause_q;
  // return target for mret
  assign epc_o          = mepc_q;
  assign m_irq_enable_o = mie_q;

  // pc source for the exception pc is one or the other
  a_save_src: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(trap_ctrl_i.save_if && trap_ctrl_i.save_id)
  );

endmodule

`default_nettype wire

//--- verilog/perf_counter.sv
// single 32-bit event counter with registered increment and saturation
`timescale 1ns/100ps
`default_nettype none

module perf_counter
  import csr_pkg::*;
(
  input  wire        clk,
  input  wire        rst_n,
  // increment request, counted one cycle later
  input  wire        inc_i,
  // hold at all ones instead of wrapping
  input  wire        sat_en_i,
  input  wire        we_i,
  input  wire xlen_t wdata_i,
  output xlen_t      count_o
);

  logic  inc_q;
  logic  at_max;
  xlen_t count_q;

  assign at_max = &count_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      inc_q   <= 1'b0;
      count_q <= '0;
    end else begin
      inc_q <= inc_i;
      // csr write beats a pending increment
      if (we_i) begin
        count_q <= wdata_i;
      end else if (inc_q && !(at_max && sat_en_i)) begin
        count_q <= count_q + 1'b1;
      end
    end
  end

  assign count_o = count_q;

endmodule

`default_nettype wire

//--- verilog/perf_event_map.sv
// core events to counter increment requests, with pcer and pcmr registers
`timescale 1ns/100ps
`default_nettype none

module perf_event_map
  import csr_pkg::*;
(
  input  wire               clk,
  input  wire               rst_n,
  input  wire perf_events_t perf_events_i,
  input  wire csr_wstrobe_t wstrobe_i,
  input  wire xlen_t        wdata_i,
  output perf_mask_t        inc_req_o,
  output perf_mask_t        pcer_o,
  output pcmr_t             pcmr_o
);

  logic       id_valid_q;
  perf_mask_t events;
  perf_mask_t pcer_q;
  pcmr_t      pcmr_q;

  ////////////////////////////////////////////////////////////////////////////
  // event conditions
  ////////////////////////////////////////////////////////////////////////////

  // cycles
  assign events[0]  = 1'b1;
  // retired instructions
  assign events[1]  = perf_events_i.id_valid & perf_events_i.is_decoding;
  // load-use and jump-register hazards, previous id_valid
  assign events[2]  = perf_events_i.ld_stall & id_valid_q;
  assign events[3]  = perf_events_i.jr_stall & id_valid_q;
  // fetch wait, not counting redirects
  assign events[4]  = perf_events_i.imiss & ~perf_events_i.pc_set;
  assign events[5]  = perf_events_i.mem_load;
  assign events[6]  = perf_events_i.mem_store;
  // control flow
  assign events[7]  = perf_events_i.jump & id_valid_q;
  assign events[8]  = perf_events_i.branch & id_valid_q;
  assign events[9]  = perf_events_i.branch & perf_events_i.branch_taken & id_valid_q;
  // compressed instructions
  assign events[10] = perf_events_i.id_valid & perf_events_i.is_decoding &
                      perf_events_i.is_compressed;

  // per-counter enable and global enable
  assign inc_req_o = events & pcer_q & {N_PERF_CNT{pcmr_q[PCMR_EN_BIT]}};

  ////////////////////////////////////////////////////////////////////////////
  // pcer, pcmr
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_valid_q <= 1'b0;
      pcer_q     <= '0;
      pcmr_q     <= PCMR_RESET;
    end else begin
      id_valid_q <= perf_events_i.id_valid;
      if (wstrobe_i.pcer) begin
        pcer_q <= wdata_i[N_PERF_CNT-1:0];
      end
      if (wstrobe_i.pcmr) begin
        pcmr_q <= wdata_i[1:0];
      end
    end
  end

  assign pcer_o = pcer_q;
  assign pcmr_o = pcmr_q;

endmodule

`default_nettype wire
